/* csr_unit.f */
hw/csr_pkg.sv
hw/csr_issue.sv
hw/csr_exec.sv
hw/csr_regfile.sv
hw/csr_unit.sv
test/csr_unit_properties.sv
test/csr_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= csr_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --assert --timing -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
	  --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qxF '** PASS **' $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --timescale $(TIMESCALE) \
	  --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/csr_unit_tb.sv */
// Testbench for csr_unit with clock, reset, directed and random CSR traffic and watchdog
`default_nettype none

module csr_unit_tb import csr_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS       = 4;
  localparam int RESET_CYCLES = 10;
  localparam int OP_CYCLES    = 3;     // Request, valid, slack
  localparam int HS_LIMIT     = 4;     // Cycles allowed for csr_valid
  localparam int N_RAND       = 16;
  localparam int N_ILL        = 8;
  localparam int RET_CYCLES   = 40;
  localparam int TEST_CYCLES  = RESET_CYCLES + 30 + 2 * RET_CYCLES + 4
                              + (8 + 2 * N_RAND + N_ILL + 3 + 5 + 11 + 5) * OP_CYCLES;
  localparam int WATCHDOG_NS  = (TEST_CYCLES + 100) * CLK_NS;

  logic        clk = 1'b0;
  logic        rst, rename_csr_write, rob_flush, rob_ret_valid, rob_csr_valid;
  logic [4:0]  rename_op, rob_csr_ecause, csr_ecause;
  logic [6:0]  rename_robid, csr_robid;
  logic [5:0]  rename_rd, csr_rd;
  logic [31:0] rename_op1, rob_csr_tval, csr_result;
  csr_imm_u    rename_imm;
  logic [31:2] rob_csr_epc, csr_tvec;
  logic        csr_valid, csr_error;
  logic [6:0]  next_robid = 7'd0;
  int          hs_errors = 0;
  int          tests_run = 0;
  int          mark = 0;   // Failure count at test start

  csr_unit dut (.*);

  always #(CLK_NS / 2) clk = ~clk;

  // Returns 1 ns into the valid cycle
  task automatic do_csr(input logic [2:0] op, input logic [11:0] addr, input logic [31:0] src);
    int waited = 0;
    @(posedge clk);
    #1;
    rename_csr_write  = 1'b1;
    rename_op         = {2'($urandom_range(0, 3)), op};  // Upper bits ignored
    rename_robid      = next_robid;
    rename_rd         = 6'($urandom);
    rename_op1        = src;
    rename_imm.raw    = $urandom;  // Reserved bits random
    rename_imm.f.addr = addr;
    rename_imm.f.zimm = src[4:0];
    next_robid        = next_robid + 7'd1;
    @(posedge clk);
    #1;
    rename_csr_write = 1'b0;
    while (!csr_valid && waited < HS_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!csr_valid) begin
      $display("no csr_valid for robid %0d within %0d cycles", rename_robid, HS_LIMIT);
      hs_errors++;
    end
  endtask

  task automatic read_csr(input logic [11:0] addr);
    do_csr({1'b0, OP_RS}, addr, 32'd0);  // Zero mask, no write
  endtask

  // One-cycle trap event from the ROB
  task automatic trap_event();
    rob_csr_valid  = 1'b1;
    rob_csr_epc    = 30'($urandom);
    rob_csr_ecause = 5'($urandom);
    rob_csr_tval   = $urandom;
    @(posedge clk);
    #1;
    rob_csr_valid = 1'b0;
  endtask

  function automatic logic [11:0] undefined_addr();
    logic [11:0] a;
    a = 12'($urandom);
    if (a inside {CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MCYCLE,
                  CSR_MINSTRET, CSR_MCYCLEH, CSR_MINSTRETH})
      a = 12'h7C0;
    return a;
  endfunction

  task automatic end_test(input string name);
    tests_run++;
    $display("test %0d %s done, %0d assertion failures", tests_run, name,
             dut.props.fail_count - mark);
    mark = dut.props.fail_count;
  endtask

  initial begin
    void'($urandom(32'h211d_cc98));
    rst = 1'b1;
    rename_csr_write = 1'b1;  // Held through reset, must not start the stage
    rename_op = 5'd0;
    rename_robid = 7'd0;
    rename_rd = 6'd0;
    rename_op1 = 32'd0;
    rename_imm = '0;
    rob_flush = 1'b0;
    rob_ret_valid = 1'b0;
    rob_csr_valid = 1'b0;
    rob_csr_epc = 30'd0;
    rob_csr_ecause = 5'd0;
    rob_csr_tval = 32'd0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    rename_csr_write = 1'b0;

    read_csr(CSR_MCYCLE);
    read_csr(CSR_MCYCLEH);
    repeat ($urandom_range(5, 15)) @(posedge clk);
    read_csr(CSR_MCYCLE);
    do_csr({1'b0, OP_RW}, CSR_MCYCLE, 32'hFFFF_FFF8);  // Carry soon reaches mcycleh
    repeat ($urandom_range(5, 15)) @(posedge clk);
    read_csr(CSR_MCYCLE);
    read_csr(CSR_MCYCLEH);
    do_csr({1'b0, OP_RW}, CSR_MCYCLEH, $urandom);
    read_csr(CSR_MCYCLEH);
    end_test("mcycle");

    for (int i = 0; i < N_RAND; i++) begin
      do_csr({1'($urandom_range(0, 1)), 2'($urandom_range(1, 3))}, CSR_MSCRATCH, $urandom);
      read_csr(CSR_MSCRATCH);
    end
    end_test("mscratch rw rs rc");

    for (int i = 0; i < N_ILL; i++) begin
      if (i % 2 == 0)
        do_csr(3'b000, CSR_MSCRATCH, $urandom);  // Op 00
      else
        do_csr({1'b0, OP_RW}, undefined_addr(), $urandom);
    end
    read_csr(CSR_MSCRATCH);
    read_csr(CSR_MTVEC);
    read_csr(CSR_MEPC);
    end_test("illegal");

    for (int i = 0; i < RET_CYCLES; i++) begin
      @(posedge clk);
      #1;
      rob_ret_valid = 1'($urandom_range(0, 1));
    end
    read_csr(CSR_MINSTRET);
    rob_ret_valid = 1'b1;  // Write lands on a retiring cycle
    do_csr({1'b0, OP_RW}, CSR_MINSTRET, 32'hFFFF_FFF0);
    for (int i = 0; i < RET_CYCLES; i++) begin
      @(posedge clk);
      #1;
      rob_ret_valid = 1'($urandom_range(0, 1));
    end
    rob_ret_valid = 1'b0;
    read_csr(CSR_MINSTRET);
    read_csr(CSR_MINSTRETH);
    end_test("minstret");

    trap_event();
    read_csr(CSR_MEPC);
    read_csr(CSR_MCAUSE);
    read_csr(CSR_MTVAL);
    do_csr({1'b0, OP_RW}, CSR_MEPC, $urandom);
    trap_event();  // Collides with the mepc write
    do_csr({1'b0, OP_RW}, CSR_MCAUSE, $urandom);
    read_csr(CSR_MEPC);
    read_csr(CSR_MCAUSE);
    for (int i = 0; i < 3; i++)
      do_csr({1'b0, 2'($urandom_range(1, 3))}, CSR_MTVEC, $urandom);
    end_test("trap and mtvec");

    do_csr({1'b0, OP_RW}, CSR_MSCRATCH, 32'hA5A5_0F0F);
    rename_csr_write = 1'b1;  // During valid, dropped
    rename_robid = 7'h7F;
    @(posedge clk);
    #1;
    rename_csr_write = 1'b0;
    read_csr(CSR_MSCRATCH);
    do_csr({1'b0, OP_RW}, CSR_MSCRATCH, $urandom);
    rob_flush = 1'b1;  // Killed in its valid cycle
    @(posedge clk);
    #1;
    rob_flush = 1'b0;
    read_csr(CSR_MSCRATCH);
    end_test("handshake and flush");

    repeat (2) @(posedge clk);
    #1;
    $display("tests %0d, assertion failures %0d, handshake errors %0d", tests_run,
             dut.props.fail_count, hs_errors);
    if (dut.props.fail_count == 0 && hs_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* test/csr_unit_properties.sv */
// Bound csr_unit checker with request tracking, shadow CSR model and concurrent assertions
`default_nettype none

module csr_unit_properties import csr_pkg::*; (
  input logic        clk, rst,
  input logic        rename_csr_write, rob_flush, rob_ret_valid, rob_csr_valid,
  input logic [4:0]  rename_op, rob_csr_ecause,
  input logic [6:0]  rename_robid,
  input logic [5:0]  rename_rd,
  input logic [31:0] rename_op1, rob_csr_tval,
  input csr_imm_u    rename_imm,
  input logic [31:2] rob_csr_epc, csr_tvec,
  input logic        csr_valid, csr_error,
  input logic [4:0]  csr_ecause,
  input logic [6:0]  csr_robid,
  input logic [5:0]  csr_rd,
  input logic [31:0] csr_result
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;        // Failed assertions so far

  logic        pend;         // Instruction in the stage
  logic [2:0]  lat_op;
  logic [11:0] lat_addr;
  logic [31:0] lat_src;      // Resolved operand, rs1 or zimm
  logic [6:0]  lat_robid;
  logic [5:0]  lat_rd;
  logic [63:0] sh_mcycle;    // Cycle count
  logic [63:0] sh_minstret;  // Retirement count
  logic [31:0] sh_mtvec, sh_mscratch, sh_mepc, sh_mcause, sh_mtval;
  logic        known, legal, do_wr, exp_valid;
  logic [31:0] old_val, new_val;

  always_comb begin
    known   = 1'b1;
    old_val = 32'd0;
    case (lat_addr)
      CSR_MTVEC:     old_val = sh_mtvec;
      CSR_MSCRATCH:  old_val = sh_mscratch;
      CSR_MEPC:      old_val = sh_mepc;
      CSR_MCAUSE:    old_val = sh_mcause;
      CSR_MTVAL:     old_val = sh_mtval;
      CSR_MCYCLE:    old_val = sh_mcycle[31:0];
      CSR_MCYCLEH:   old_val = sh_mcycle[63:32];
      CSR_MINSTRET:  old_val = sh_minstret[31:0];
      CSR_MINSTRETH: old_val = sh_minstret[63:32];
      default:       known = 1'b0;
    endcase
    legal = known && (lat_op[1:0] != 2'b00);
    case (lat_op[1:0])
      OP_RW:   new_val = lat_src;               // Replace
      OP_RS:   new_val = old_val | lat_src;     // OR
      OP_RC:   new_val = old_val & ~lat_src;    // AND-NOT
      default: new_val = old_val;
    endcase
    exp_valid = pend && !rob_flush;             // Flush kills it
    // Zero mask with set or clear is a pure read
    do_wr = exp_valid && legal && !(lat_op[1:0] != OP_RW && lat_src == 32'd0);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend        <= 1'b0;
      sh_mcycle   <= 64'd0;
      sh_minstret <= 64'd0;
      sh_mtvec    <= 32'd0;
      sh_mscratch <= 32'd0;
      sh_mepc     <= 32'd0;
      sh_mcause   <= 32'd0;
      sh_mtval    <= 32'd0;
    end else begin
      pend <= rename_csr_write && !pend;  // Request during valid is dropped
      if (rename_csr_write && !pend) begin
        lat_op    <= rename_op[2:0];
        lat_addr  <= rename_imm.f.addr;
        lat_src   <= rename_op[OP_IMM_BIT] ? {27'd0, rename_imm.f.zimm} : rename_op1;
        lat_robid <= rename_robid;
        lat_rd    <= rename_rd;
      end
      sh_mcycle   <= sh_mcycle + 64'd1;
      sh_minstret <= sh_minstret + 64'(rob_ret_valid);
      if (do_wr) begin
        case (lat_addr)
          CSR_MTVEC:     sh_mtvec    <= new_val;
          CSR_MSCRATCH:  sh_mscratch <= new_val;
          CSR_MEPC:      sh_mepc     <= {new_val[31:2], 2'b00};  // Word aligned
          CSR_MCAUSE:    sh_mcause   <= new_val;
          CSR_MTVAL:     sh_mtval    <= new_val;
          CSR_MCYCLE:    sh_mcycle   <= {sh_mcycle[63:32], new_val};
          CSR_MCYCLEH:   sh_mcycle   <= {new_val, sh_mcycle[31:0]};
          CSR_MINSTRET:  sh_minstret <= {sh_minstret[63:32], new_val};
          CSR_MINSTRETH: sh_minstret <= {new_val, sh_minstret[31:0]};
          default: ;
        endcase
      end
      // Trap capture last, wins over the write
      if (rob_csr_valid) begin
        sh_mepc   <= {rob_csr_epc, 2'b00};
        sh_mcause <= {27'd0, rob_csr_ecause};
        sh_mtval  <= rob_csr_tval;
      end
    end
  end

  a_valid: assert property (@(posedge clk) disable iff (rst) csr_valid == exp_valid)
    else begin
      fail_count = fail_count + 1;
      $error("ERR csr_valid exp %h got %h", $sampled(exp_valid), $sampled(csr_valid));
    end
  a_tag: assert property (@(posedge clk) disable iff (rst)
      csr_valid |-> csr_robid == lat_robid && csr_rd == lat_rd)
    else begin
      fail_count = fail_count + 1;
      $error("ERR csr_robid exp %h got %h csr_rd exp %h got %h", $sampled(lat_robid),
             $sampled(csr_robid), $sampled(lat_rd), $sampled(csr_rd));
    end
  a_result: assert property (@(posedge clk) disable iff (rst)
      csr_valid && legal |-> !csr_error && csr_ecause == ECAUSE_NONE && csr_result == old_val)
    else begin
      fail_count = fail_count + 1;
      $error("ERR csr_result exp %h got %h csr_error %h", $sampled(old_val),
             $sampled(csr_result), $sampled(csr_error));
    end
  a_illegal: assert property (@(posedge clk) disable iff (rst)
      csr_valid && !legal |-> csr_error && csr_ecause == ECAUSE_ILLEGAL && csr_result == 32'd0)
    else begin
      fail_count = fail_count + 1;
      $error("ERR csr_ecause exp %h got %h csr_result %h", ECAUSE_ILLEGAL,
             $sampled(csr_ecause), $sampled(csr_result));
    end
  a_tvec: assert property (@(posedge clk) disable iff (rst) csr_tvec == sh_mtvec[31:2])
    else begin
      fail_count = fail_count + 1;
      $error("ERR csr_tvec exp %h got %h", $sampled(sh_mtvec[31:2]), $sampled(csr_tvec));
    end
  a_reset: assert property (@(posedge clk) rst |=> !csr_valid && !csr_error)
    else begin
      fail_count = fail_count + 1;
      $error("csr_valid or csr_error high right after reset");
    end

endmodule

bind csr_unit csr_unit_properties props (.*);

`default_nettype wire

/* hw/csr_unit.sv */
// CSR unit top level: issue stage, execute and register file
`default_nettype none

module csr_unit import csr_pkg::*; (
  input  logic        clk,
  input  logic        rst,

  // Rename
  input  logic        rename_csr_write,
  input  logic [4:0]  rename_op,
  input  logic [6:0]  rename_robid,
  input  logic [5:0]  rename_rd,
  input  logic [31:0] rename_op1,
  input  csr_imm_u    rename_imm,

  // Writeback, csr_valid doubles as the rename stall
  output logic        csr_valid,
  output logic        csr_error,
  output logic [4:0]  csr_ecause,
  output logic [6:0]  csr_robid,
  output logic [5:0]  csr_rd,
  output logic [31:0] csr_result,

  // ROB
  input  logic        rob_flush,
  input  logic        rob_ret_valid,
  input  logic        rob_csr_valid,
  input  logic [31:2] rob_csr_epc,
  input  logic [4:0]  rob_csr_ecause,
  input  logic [31:0] rob_csr_tval,
  output logic [31:2] csr_tvec
);

  // Issue to exec
  logic                 iss_valid;
  logic [2:0]           iss_op;
  logic [6:0]           iss_robid;
  logic [5:0]           iss_rd;
  logic [31:0]          iss_src;
  logic [11:0]          iss_addr;

  // Exec to regfile
  logic [IDX_WIDTH-1:0] rd_index;
  logic [31:0]          rd_data;
  logic                 wr_en;
  logic [IDX_WIDTH-1:0] wr_index;
  logic [31:0]          wr_data;

  csr_issue u_issue (
    .clk, .rst,
    .rename_csr_write, .rename_op, .rename_robid, .rename_rd,
    .rename_op1, .rename_imm,
    .rob_flush,
    .iss_valid, .iss_op, .iss_robid, .iss_rd, .iss_src, .iss_addr
  );

  csr_exec u_exec (
    .iss_valid, .iss_op, .iss_robid, .iss_rd, .iss_src, .iss_addr,
    .rd_index, .rd_data,
    .wr_en, .wr_index, .wr_data,
    .csr_valid, .csr_error, .csr_ecause, .csr_robid, .csr_rd, .csr_result
  );

  csr_regfile u_regfile (
    .clk, .rst,
    .rd_index, .rd_data,
    .wr_en, .wr_index, .wr_data,
    .rob_ret_valid, .rob_csr_valid, .rob_csr_epc, .rob_csr_ecause, .rob_csr_tval,
    .csr_tvec
  );

endmodule

`default_nettype wire

/* hw/csr_regfile.sv */
// CSR register file: 64-bit counters, mscratch, trap registers, trap capture and read mux
`default_nettype none

module csr_regfile import csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,

  // Exec ports
  input  logic [IDX_WIDTH-1:0] rd_index,
  output logic [31:0]          rd_data,
  input  logic                 wr_en,
  input  logic [IDX_WIDTH-1:0] wr_index,
  input  logic [31:0]          wr_data,

  // From the ROB
  input  logic                 rob_ret_valid,
  input  logic                 rob_csr_valid,
  input  logic [31:2]          rob_csr_epc,
  input  logic [4:0]           rob_csr_ecause,
  input  logic [31:0]          rob_csr_tval,

  // To fetch
  output logic [31:2]          csr_tvec
);

  logic [63:0] mcycle;
  logic [63:0] minstret;
  logic [31:0] mtvec;
  logic [31:0] mscratch;
  logic [31:2] mepc;      // Word aligned, low bits read as zero
  logic [31:0] mcause;
  logic [31:0] mtval;

  logic [63:0] mcycle_n;
  logic [63:0] minstret_n;

  // Per-register write strobes
  logic wr_mtvec, wr_mscratch, wr_mepc, wr_mcause, wr_mtval;
  logic wr_mcycle, wr_mcycleh, wr_minstret, wr_minstreth;

  assign wr_mtvec     = wr_en & (wr_index == IDX_MTVEC);
  assign wr_mscratch  = wr_en & (wr_index == IDX_MSCRATCH);
  assign wr_mepc      = wr_en & (wr_index == IDX_MEPC);
  assign wr_mcause    = wr_en & (wr_index == IDX_MCAUSE);
  assign wr_mtval     = wr_en & (wr_index == IDX_MTVAL);
  assign wr_mcycle    = wr_en & (wr_index == IDX_MCYCLE);
  assign wr_mcycleh   = wr_en & (wr_index == IDX_MCYCLEH);
  assign wr_minstret  = wr_en & (wr_index == IDX_MINSTRET);
  assign wr_minstreth = wr_en & (wr_index == IDX_MINSTRETH);

  // Counter next values
  // A half write replaces the increment, other half holds
  always_comb begin
    mcycle_n   = mcycle + 64'd1;
    minstret_n = minstret + {63'd0, rob_ret_valid};
    if (wr_mcycle)
      mcycle_n = {mcycle[63:32], wr_data};
    else if (wr_mcycleh)
      mcycle_n = {wr_data, mcycle[31:0]};
    if (wr_minstret)
      minstret_n = {minstret[63:32], wr_data};
    else if (wr_minstreth)
      minstret_n = {wr_data, minstret[31:0]};
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle   <= 64'd0;
      minstret <= 64'd0;
      mtvec    <= 32'd0;
      mscratch <= 32'd0;
      mepc     <= 30'd0;
      mcause   <= 32'd0;
      mtval    <= 32'd0;
    end else begin
      mcycle   <= mcycle_n;
      minstret <= minstret_n;
      if (wr_mtvec)
        mtvec <= wr_data;
      if (wr_mscratch)
        mscratch <= wr_data;
      // Trap capture wins over an instruction write
      if (rob_csr_valid) begin
        mepc   <= rob_csr_epc;
        mcause <= {27'd0, rob_csr_ecause};
        mtval  <= rob_csr_tval;
      end else begin
        if (wr_mepc)
          mepc <= wr_data[31:2];
        if (wr_mcause)
          mcause <= wr_data;
        if (wr_mtval)
          mtval <= wr_data;
      end
    end
  end

  // Read mux
  always_comb begin
    case (rd_index)
      IDX_MTVEC:     rd_data = mtvec;
      IDX_MSCRATCH:  rd_data = mscratch;
      IDX_MEPC:      rd_data = {mepc, 2'b00};
      IDX_MCAUSE:    rd_data = mcause;
      IDX_MTVAL:     rd_data = mtval;
      IDX_MCYCLE:    rd_data = mcycle[31:0];
      IDX_MCYCLEH:   rd_data = mcycle[63:32];
      IDX_MINSTRET:  rd_data = minstret[31:0];
      IDX_MINSTRETH: rd_data = minstret[63:32];
      default:       rd_data = 32'd0;
    endcase
  end

  assign csr_tvec = mtvec[31:2];  // Straight from the register, mode bits dropped

endmodule

`default_nettype wire

/* hw/csr_exec.sv */
// CSR execute: address decode, illegal check, read-modify-write value and writeback drive
`default_nettype none

module csr_exec import csr_pkg::*; (
  // From issue
  input  logic                 iss_valid,
  input  logic [2:0]           iss_op,
  input  logic [6:0]           iss_robid,
  input  logic [5:0]           iss_rd,
  input  logic [31:0]          iss_src,
  input  logic [11:0]          iss_addr,

  // Register file read port
  output logic [IDX_WIDTH-1:0] rd_index,
  input  logic [31:0]          rd_data,

  // Register file write port
  output logic                 wr_en,
  output logic [IDX_WIDTH-1:0] wr_index,
  output logic [31:0]          wr_data,

  // To writeback
  output logic                 csr_valid,
  output logic                 csr_error,
  output logic [4:0]           csr_ecause,
  output logic [6:0]           csr_robid,
  output logic [5:0]           csr_rd,
  output logic [31:0]          csr_result
);

  logic [IDX_WIDTH-1:0] idx;
  logic                 addr_ok;
  logic                 illegal;
  logic                 no_change;
  logic [31:0]          new_val;

  // Address to register index
  always_comb begin
    addr_ok = 1'b1;
    idx     = IDX_MTVEC;
    case (iss_addr)
      CSR_MTVEC:     idx = IDX_MTVEC;
      CSR_MSCRATCH:  idx = IDX_MSCRATCH;
      CSR_MEPC:      idx = IDX_MEPC;
      CSR_MCAUSE:    idx = IDX_MCAUSE;
      CSR_MTVAL:     idx = IDX_MTVAL;
      CSR_MCYCLE:    idx = IDX_MCYCLE;
      CSR_MCYCLEH:   idx = IDX_MCYCLEH;
      CSR_MINSTRET:  idx = IDX_MINSTRET;
      CSR_MINSTRETH: idx = IDX_MINSTRETH;
      default:       addr_ok = 1'b0;  // Undefined CSR
    endcase
  end

  // Op 00 has no meaning
  assign illegal = ~addr_ok | (iss_op[1:0] == 2'b00);

  // Read-modify-write
  always_comb begin
    case (iss_op[1:0])
      OP_RW:   new_val = iss_src;
      OP_RS:   new_val = rd_data | iss_src;
      OP_RC:   new_val = rd_data & ~iss_src;
      default: new_val = rd_data;  // Never written, illegal
    endcase
  end

  // Set or clear with a zero mask changes nothing
  // Skipping the write lets a counter keep counting during a plain read
  assign no_change = (iss_op[1:0] != OP_RW) & (iss_src == 32'd0);

  assign rd_index = idx;
  assign wr_index = idx;
  assign wr_data  = new_val;
  assign wr_en    = iss_valid & ~illegal & ~no_change;

  // Writeback, meaningful only while csr_valid
  assign csr_valid  = iss_valid;
  assign csr_error  = iss_valid & illegal;          // Low whenever nothing is in the stage
  assign csr_ecause = illegal ? ECAUSE_ILLEGAL : ECAUSE_NONE;
  assign csr_robid  = iss_robid;
  assign csr_rd     = iss_rd;
  assign csr_result = illegal ? 32'd0 : rd_data;    // Old value

endmodule

`default_nettype wire

/* hw/csr_issue.sv */
// CSR issue stage: request latch, one-cycle rename stall, source select and flush
`default_nettype none

module csr_issue import csr_pkg::*; (
  input  logic        clk,
  input  logic        rst,

  // From rename
  input  logic        rename_csr_write,
  input  logic [4:0]  rename_op,
  input  logic [6:0]  rename_robid,
  input  logic [5:0]  rename_rd,
  input  logic [31:0] rename_op1,
  input  csr_imm_u    rename_imm,

  input  logic        rob_flush,

  // To exec
  output logic        iss_valid,
  output logic [2:0]  iss_op,
  output logic [6:0]  iss_robid,
  output logic [5:0]  iss_rd,
  output logic [31:0] iss_src,
  output logic [11:0] iss_addr
);

  logic        valid_q;
  logic        accept;
  logic [31:0] src_sel;

  // Stage empty and no flush pending
  // valid_q blocks back-to-back acceptance so valid lasts one cycle
  assign accept = rename_csr_write & ~valid_q & ~rob_flush;

  // Immediate form uses zero-extended zimm
  assign src_sel = rename_op[OP_IMM_BIT] ? {27'd0, rename_imm.f.zimm} : rename_op1;

  always_ff @(posedge clk) begin
    if (rst)
      valid_q <= 1'b0;
    else
      valid_q <= accept;  // Self-clearing after one cycle
  end

  // Payload only moves on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      iss_op    <= rename_op[2:0];  // rename_op[4:3] carry no CSR meaning
      iss_robid <= rename_robid;
      iss_rd    <= rename_rd;
      iss_src   <= src_sel;
      iss_addr  <= rename_imm.f.addr;
    end
  end

  // Flush kills the instruction in its valid cycle
  assign iss_valid = valid_q & ~rob_flush;

endmodule

`default_nettype wire

/* hw/csr_pkg.sv */
// CSR addresses, register indexes, operation codes, exception causes and immediate union
`default_nettype none

package csr_pkg;

  // Machine CSR addresses handled by the unit
  localparam logic [11:0] CSR_MTVEC     = 12'h305;
  localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
  localparam logic [11:0] CSR_MEPC      = 12'h341;
  localparam logic [11:0] CSR_MCAUSE    = 12'h342;
  localparam logic [11:0] CSR_MTVAL     = 12'h343;
  localparam logic [11:0] CSR_MCYCLE    = 12'hB00;
  localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
  localparam logic [11:0] CSR_MCYCLEH   = 12'hB80;
  localparam logic [11:0] CSR_MINSTRETH = 12'hB82;

  // Internal register index, shared by exec decode and regfile mux
  localparam int IDX_WIDTH = 4;

  localparam logic [IDX_WIDTH-1:0] IDX_MTVEC     = 4'd0;
  localparam logic [IDX_WIDTH-1:0] IDX_MSCRATCH  = 4'd1;
  localparam logic [IDX_WIDTH-1:0] IDX_MEPC      = 4'd2;
  localparam logic [IDX_WIDTH-1:0] IDX_MCAUSE    = 4'd3;
  localparam logic [IDX_WIDTH-1:0] IDX_MTVAL     = 4'd4;
  localparam logic [IDX_WIDTH-1:0] IDX_MCYCLE    = 4'd5;
  localparam logic [IDX_WIDTH-1:0] IDX_MCYCLEH   = 4'd6;
  localparam logic [IDX_WIDTH-1:0] IDX_MINSTRET  = 4'd7;
  localparam logic [IDX_WIDTH-1:0] IDX_MINSTRETH = 4'd8;

  // op[1:0] encodings, 00 is illegal
  localparam logic [1:0] OP_RW = 2'b01;  // Replace
  localparam logic [1:0] OP_RS = 2'b10;  // Set bits
  localparam logic [1:0] OP_RC = 2'b11;  // Clear bits

  // op[2] picks zimm over rs1
  localparam int OP_IMM_BIT = 2;

  // Exception causes reported to the ROB
  localparam logic [4:0] ECAUSE_NONE    = 5'd0;
  localparam logic [4:0] ECAUSE_ILLEGAL = 5'd2;  // Illegal instruction

  // Rename immediate word
  // Same 32 bits seen either raw or split into the CSR fields
  typedef struct packed {
    logic [14:0] rsvd;   // Bits 31..17, not used by CSR ops
    logic [4:0]  zimm;   // Bits 16..12
    logic [11:0] addr;   // Bits 11..0
  } csr_imm_fields_t;

  typedef union packed {
    logic [31:0]     raw;
    csr_imm_fields_t f;
  } csr_imm_u;

endpackage

`default_nettype wire
